// File: common/octo_settings.svh
`ifndef OCTO_SETTINGS_SVH
`define OCTO_SETTINGS_SVH

// datapath widths
`define OCTO_WORD_W     32
`define OCTO_OP_W       7
`define OCTO_REG_IDX_W  3
`define OCTO_IMM_W      16
`define OCTO_REG_COUNT  8

// word-addressed memory, one entry per address
`define OCTO_ADDR_W     10
`define OCTO_MEM_DEPTH  (1 << `OCTO_ADDR_W)

// instruction field positions
`define OCTO_OP_MSB     6
`define OCTO_OP_LSB     0
`define OCTO_RA_MSB     9
`define OCTO_RA_LSB     7
`define OCTO_RB_MSB     12
`define OCTO_RB_LSB     10
`define OCTO_RD_MSB     15
`define OCTO_RD_LSB     13
`define OCTO_IMM_MSB    31
`define OCTO_IMM_LSB    16

// opcodes, anything not listed runs as a no-op
`define OP_ADD          7'h01
`define OP_SUB          7'h02
`define OP_AND          7'h03
`define OP_OR           7'h04
`define OP_XOR          7'h05
`define OP_ADDI         7'h06
`define OP_SETLO        7'h07
`define OP_SETHI        7'h08
`define OP_BRF          7'h09
`define OP_JMP          7'h0a
`define OP_LOAD         7'h0b
`define OP_STORE        7'h0c
`define OP_HALT         7'h0d

`endif

// File: common/octo_pkg.sv
`include "octo_settings.svh"

package octo_pkg;

    // data word, instruction word or register value
    typedef logic [`OCTO_WORD_W-1:0] word_t;

    // memory word address, also the program counter
    typedef logic [`OCTO_ADDR_W-1:0] addr_t;

    typedef logic [`OCTO_REG_IDX_W-1:0] reg_idx_t;

    typedef logic [`OCTO_OP_W-1:0] opcode_t;

    typedef logic [`OCTO_IMM_W-1:0] imm_t;

    // LWAIT is only entered by loads
    typedef enum logic [2:0] {
        IFETCH,
        ILATCH,
        EXEC,
        LWAIT,
        HALTED
    } cpu_state_t;

endpackage

// File: cpu/octo_alu.sv
`timescale 1ns/1ps
`include "octo_settings.svh"

module octo_alu (
    input  octo_pkg::opcode_t op,
    input  octo_pkg::word_t   a,
    input  octo_pkg::word_t   b,
    input  octo_pkg::imm_t    imm,
    input  octo_pkg::word_t   rd_old,
    output octo_pkg::word_t   result,
    output logic              flag
);
    import octo_pkg::*;

    word_t                  imm_sext;
    logic [`OCTO_WORD_W:0]  add_sum;
    logic [`OCTO_WORD_W:0]  addi_sum;

    assign imm_sext = {{(`OCTO_WORD_W - `OCTO_IMM_W){imm[`OCTO_IMM_W-1]}}, imm};

    // one extra bit on each adder holds the carry out
    assign add_sum  = {1'b0, a} + {1'b0, b};
    assign addi_sum = {1'b0, a} + {1'b0, imm_sext};

    always_comb
    begin
        result = '0;
        flag   = 1'b0;
        case (op)
            `OP_ADD:
            begin
                result = add_sum[`OCTO_WORD_W-1:0];
                flag   = add_sum[`OCTO_WORD_W];
            end
            `OP_ADDI:
            begin
                result = addi_sum[`OCTO_WORD_W-1:0];
                flag   = addi_sum[`OCTO_WORD_W];
            end
            `OP_SUB:
            begin
                result = a - b;
                // borrow when a is below b, unsigned
                flag   = (a < b);
            end
            `OP_AND:
            begin
                result = a & b;
                flag   = (result == '0);
            end
            `OP_OR:
            begin
                result = a | b;
                flag   = (result == '0);
            end
            `OP_XOR:
            begin
                result = a ^ b;
                flag   = (result == '0);
            end
            `OP_SETLO:
            begin
                // the upper half of rd is kept
                result = {rd_old[`OCTO_WORD_W-1:`OCTO_IMM_W], imm};
                flag   = (result == '0);
            end
            `OP_SETHI:
            begin
                result = {imm, rd_old[`OCTO_IMM_W-1:0]};
                flag   = (result == '0);
            end
            default:
            begin
                result = '0;
                flag   = 1'b0;
            end
        endcase
    end

endmodule

// File: cpu/octo_regfile.sv
`timescale 1ns/1ps
`include "octo_settings.svh"

module octo_regfile (
    input  logic               clock,
    input  logic               rst_n,
    input  octo_pkg::reg_idx_t ra_idx,
    input  octo_pkg::reg_idx_t rb_idx,
    input  octo_pkg::reg_idx_t rd_idx,
    output octo_pkg::word_t    ra_data,
    output octo_pkg::word_t    rb_data,
    output octo_pkg::word_t    rd_data,
    output logic               ra_flag,
    input  logic               we,
    input  octo_pkg::reg_idx_t wr_idx,
    input  octo_pkg::word_t    wr_data,
    input  logic               wr_flag_en,
    input  logic               wr_flag
);
    import octo_pkg::*;

    word_t                      regs [`OCTO_REG_COUNT];
    logic [`OCTO_REG_COUNT-1:0] flags;

    // reads are combinational, rd is read for the half-word merge
    assign ra_data = regs[ra_idx];
    assign rb_data = regs[rb_idx];
    assign rd_data = regs[rd_idx];
    assign ra_flag = flags[ra_idx];

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `OCTO_REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
            flags <= '0;
        end
        else if (we)
        begin
            regs[wr_idx] <= wr_data;
            if (wr_flag_en)
            begin
                flags[wr_idx] <= wr_flag;
            end
        end
    end

    // a flag only ever changes along with its register
    a_flag_with_write: assert property (
        @(posedge clock) disable iff (!rst_n)
        wr_flag_en |-> we
    );

endmodule

// File: cpu/octo_cpu.sv
`timescale 1ns/1ps
`include "octo_settings.svh"

module octo_cpu (
    input  logic            clock,
    input  logic            rst_n,
    output octo_pkg::addr_t mem_addr,
    output octo_pkg::word_t mem_wdata,
    output logic            mem_we,
    input  octo_pkg::word_t mem_rdata,
    output logic            halted
);
    import octo_pkg::*;

    cpu_state_t state;
    addr_t      pc;
    addr_t      pc_next;
    word_t      ir;

    opcode_t    op;
    reg_idx_t   ra_idx;
    reg_idx_t   rb_idx;
    reg_idx_t   rd_idx;
    imm_t       imm;

    word_t      ra_data;
    word_t      rb_data;
    word_t      rd_data;
    logic       ra_flag;

    word_t      alu_result;
    logic       alu_flag;
    logic       is_alu;
    logic       is_mem;

    logic       rf_we;
    logic       rf_flag_en;
    word_t      rf_wdata;

    assign op     = ir[`OCTO_OP_MSB:`OCTO_OP_LSB];
    assign ra_idx = ir[`OCTO_RA_MSB:`OCTO_RA_LSB];
    assign rb_idx = ir[`OCTO_RB_MSB:`OCTO_RB_LSB];
    assign rd_idx = ir[`OCTO_RD_MSB:`OCTO_RD_LSB];
    assign imm    = ir[`OCTO_IMM_MSB:`OCTO_IMM_LSB];

    always_comb
    begin
        case (op)
            `OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_XOR,
            `OP_ADDI, `OP_SETLO, `OP_SETHI: is_alu = 1'b1;
            default:                        is_alu = 1'b0;
        endcase
    end

    assign is_mem = (op == `OP_LOAD) || (op == `OP_STORE);

    // only loads and stores in EXEC use rb as the address, otherwise the pc is on the bus
    assign mem_addr  = (state == EXEC && is_mem) ? addr_t'(rb_data) : pc;
    assign mem_wdata = ra_data;
    assign mem_we    = (state == EXEC) && (op == `OP_STORE);
    assign halted    = (state == HALTED);

    // load data arrives in LWAIT and leaves the flag alone
    assign rf_we      = (state == EXEC && is_alu) || (state == LWAIT);
    assign rf_flag_en = (state == EXEC && is_alu);
    assign rf_wdata   = (state == LWAIT) ? mem_rdata : alu_result;

    always_comb
    begin
        case (op)
            `OP_BRF:  pc_next = ra_flag ? addr_t'(imm) : pc + addr_t'(1);
            `OP_JMP:  pc_next = addr_t'(imm);
            `OP_HALT: pc_next = pc;
            default:  pc_next = pc + addr_t'(1);
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            state <= IFETCH;
            pc    <= '0;
        end
        else
        begin
            case (state)
                IFETCH: state <= ILATCH;
                ILATCH: state <= EXEC;
                EXEC:
                begin
                    pc <= pc_next;
                    if (op == `OP_LOAD)
                        state <= LWAIT;
                    else if (op == `OP_HALT)
                        state <= HALTED;
                    else
                        state <= IFETCH;
                end
                LWAIT:   state <= IFETCH;
                HALTED:  state <= HALTED;
                default: state <= IFETCH;
            endcase
        end
    end

    // memory read data is valid one cycle after the fetch address
    always_ff @(posedge clock)
    begin
        if (state == ILATCH)
        begin
            ir <= mem_rdata;
        end
    end

    octo_alu u_alu (
        .op     (op),
        .a      (ra_data),
        .b      (rb_data),
        .imm    (imm),
        .rd_old (rd_data),
        .result (alu_result),
        .flag   (alu_flag)
    );

    octo_regfile u_regfile (
        .clock      (clock),
        .rst_n      (rst_n),
        .ra_idx     (ra_idx),
        .rb_idx     (rb_idx),
        .rd_idx     (rd_idx),
        .ra_data    (ra_data),
        .rb_data    (rb_data),
        .rd_data    (rd_data),
        .ra_flag    (ra_flag),
        .we         (rf_we),
        .wr_idx     (rd_idx),
        .wr_data    (rf_wdata),
        .wr_flag_en (rf_flag_en),
        .wr_flag    (alu_flag)
    );

    // a store strobe only comes in EXEC after a STORE word was fetched
    a_store_in_exec: assert property (
        @(posedge clock) disable iff (!rst_n)
        mem_we |-> (state == EXEC)
                   && ($past(mem_rdata[`OCTO_OP_MSB:`OCTO_OP_LSB]) == `OP_STORE)
    );

    a_halt_sticks: assert property (
        @(posedge clock) disable iff (!rst_n)
        (state == HALTED) |=> (state == HALTED)
    );

endmodule

// File: logic/octo_memory.sv
`timescale 1ns/1ps
`include "octo_settings.svh"

module octo_memory (
    input  logic            clock,
    input  octo_pkg::addr_t addr,
    input  octo_pkg::word_t wdata,
    input  logic            we,
    output octo_pkg::word_t rdata,
    input  logic            load_en,
    input  octo_pkg::addr_t load_addr,
    input  octo_pkg::word_t load_data
);
    import octo_pkg::*;

    word_t mem [`OCTO_MEM_DEPTH];

    always_ff @(posedge clock)
    begin
        // the load port wins over a processor write
        if (load_en)
        begin
            mem[load_addr] <= load_data;
        end
        else if (we)
        begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

    // programs are only loaded while the processor sits in reset
    a_no_load_during_store: assert property (
        @(posedge clock)
        we |-> !load_en
    );

endmodule

// File: logic/octo_system.sv
`timescale 1ns/1ps

module octo_system (
    input  logic            clock,
    input  logic            rst_n,
    input  logic            load_en,
    input  octo_pkg::addr_t load_addr,
    input  octo_pkg::word_t load_data,
    output logic            store_valid,
    output octo_pkg::addr_t store_addr,
    output octo_pkg::word_t store_data,
    output logic            halted
);
    import octo_pkg::*;

    word_t mem_rdata;

    // the processor memory strobes double as the store outputs
    octo_cpu u_cpu (
        .clock     (clock),
        .rst_n     (rst_n),
        .mem_addr  (store_addr),
        .mem_wdata (store_data),
        .mem_we    (store_valid),
        .mem_rdata (mem_rdata),
        .halted    (halted)
    );

    octo_memory u_memory (
        .clock     (clock),
        .addr      (store_addr),
        .wdata     (store_data),
        .we        (store_valid),
        .rdata     (mem_rdata),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

endmodule

// File: test/octo_isa_model.svh
`ifndef OCTO_ISA_MODEL_SVH
`define OCTO_ISA_MODEL_SVH

// interprets an image instruction by instruction and returns 1 when HALT is reached
function automatic logic isa_run(input word_t img [`OCTO_MEM_DEPTH],
                                 input int max_steps,
                                 output addr_t st_addr [$],
                                 output word_t st_data [$]);
    word_t                      mem [`OCTO_MEM_DEPTH];
    word_t                      r [`OCTO_REG_COUNT];
    logic [`OCTO_REG_COUNT-1:0] f;
    logic [`OCTO_WORD_W:0]      sum;
    word_t                      ins;
    addr_t                      pc;
    opcode_t                    op;
    reg_idx_t                   ra;
    reg_idx_t                   rb;
    reg_idx_t                   rd;
    imm_t                       imm;
    mem = img;
    f   = '0;
    pc  = '0;
    st_addr.delete();
    st_data.delete();
    for (int i = 0; i < `OCTO_REG_COUNT; i++)
    begin
        r[i] = '0;
    end
    for (int step = 0; step < max_steps; step++)
    begin
        ins = mem[pc];
        op  = ins[`OCTO_OP_MSB:`OCTO_OP_LSB];
        ra  = ins[`OCTO_RA_MSB:`OCTO_RA_LSB];
        rb  = ins[`OCTO_RB_MSB:`OCTO_RB_LSB];
        rd  = ins[`OCTO_RD_MSB:`OCTO_RD_LSB];
        imm = ins[`OCTO_IMM_MSB:`OCTO_IMM_LSB];
        pc  = pc + 1'b1;
        case (op)
            `OP_ADD:
            begin
                sum   = {1'b0, r[ra]} + {1'b0, r[rb]};
                r[rd] = sum[`OCTO_WORD_W-1:0];
                f[rd] = sum[`OCTO_WORD_W];
            end
            `OP_ADDI:
            begin
                sum   = {1'b0, r[ra]} + {1'b0, {(`OCTO_WORD_W - `OCTO_IMM_W){imm[15]}}, imm};
                r[rd] = sum[`OCTO_WORD_W-1:0];
                f[rd] = sum[`OCTO_WORD_W];
            end
            `OP_SUB:
            begin
                // borrow is taken from the operands before rd changes
                f[rd] = r[ra] < r[rb];
                r[rd] = r[ra] - r[rb];
            end
            `OP_AND:   r[rd] = r[ra] & r[rb];
            `OP_OR:    r[rd] = r[ra] | r[rb];
            `OP_XOR:   r[rd] = r[ra] ^ r[rb];
            `OP_SETLO: r[rd][`OCTO_IMM_W-1:0] = imm;
            `OP_SETHI: r[rd][`OCTO_WORD_W-1:`OCTO_IMM_W] = imm;
            `OP_BRF:
            begin
                if (f[ra])
                    pc = addr_t'(imm);
            end
            `OP_JMP:   pc = addr_t'(imm);
            `OP_LOAD:  r[rd] = mem[addr_t'(r[rb])];
            `OP_STORE:
            begin
                mem[addr_t'(r[rb])] = r[ra];
                st_addr.push_back(addr_t'(r[rb]));
                st_data.push_back(r[ra]);
            end
            `OP_HALT:  return 1'b1;
            default:   ;
        endcase
        if (op inside {`OP_AND, `OP_OR, `OP_XOR, `OP_SETLO, `OP_SETHI})
            f[rd] = (r[rd] == '0);
    end
    return 1'b0;
endfunction

`endif

// File: test/octo_tb.sv
`timescale 1ns/1ps
`include "octo_settings.svh"

module octo_tb;
    import octo_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int STEP_LIMIT   = 200;
    localparam int IDLE_CYCLES  = 50;
    localparam int RUN_COUNT    = 9;
    // every run loads the whole memory, then allows four cycles per instruction
    localparam int RUN_CYCLES   = `OCTO_MEM_DEPTH + RESET_CYCLES + IDLE_CYCLES
                                  + 4 * STEP_LIMIT + 4;
    localparam int WATCHDOG_NS  = RUN_COUNT * RUN_CYCLES * CLK_PERIOD * 2;

    logic        clock;
    logic        rst_n;
    logic        load_en;
    addr_t       load_addr;
    word_t       load_data;
    logic        store_valid;
    addr_t       store_addr;
    word_t       store_data;
    logic        halted;

    word_t       image [`OCTO_MEM_DEPTH];
    int          plen;
    addr_t       got_addr [$];
    word_t       got_data [$];
    addr_t       exp_addr [$];
    word_t       exp_data [$];
    logic [31:0] lcg_state;
    int          errors;
    int          tests_run;
    int          tests_failed;

    `include "octo_isa_model.svh"

    octo_system DUT (
        .clock       (clock),
        .rst_n       (rst_n),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .store_valid (store_valid),
        .store_addr  (store_addr),
        .store_data  (store_data),
        .halted      (halted)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    always @(posedge clock)
    begin
        if (rst_n && store_valid)
        begin
            got_addr.push_back(store_addr);
            got_data.push_back(store_data);
        end
    end

    function automatic void emit(input opcode_t op, input reg_idx_t rd, input reg_idx_t ra,
                                 input reg_idx_t rb, input imm_t imm);
        image[plen] = {imm, rd, rb, ra, op};
        plen++;
    endfunction

    // taken path stores r6, fall-through stores r5, both at the address in r7
    function automatic void emit_branch(input reg_idx_t flag_reg);
        int p;
        p = plen;
        emit(`OP_BRF, 0, flag_reg, 0, imm_t'(p + 3));
        emit(`OP_STORE, 0, 5, 7, 16'h0);
        emit(`OP_JMP, 0, 0, 0, imm_t'(p + 4));
        emit(`OP_STORE, 0, 6, 7, 16'h0);
    endfunction

    // words outside the program are HALTs tagged with their address
    function automatic void clear_image();
        for (int a = 0; a < `OCTO_MEM_DEPTH; a++)
        begin
            image[a] = {16'(a) ^ 16'ha5c3, 9'(a), `OP_HALT};
        end
        plen = 0;
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp)
        begin
            $display("error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            $display("error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // loads the image under reset, runs it to HALT and compares the stores with the model
    task automatic run_image(input string name, input int idle_cycles);
        int   errors_before;
        int   cycles;
        int   seen;
        logic exp_halted;
        errors_before = errors;
        @(posedge clock);
        rst_n <= 1'b0;
        for (int a = 0; a < `OCTO_MEM_DEPTH; a++)
        begin
            @(posedge clock);
            load_en   <= 1'b1;
            load_addr <= addr_t'(a);
            load_data <= image[a];
        end
        @(posedge clock);
        load_en <= 1'b0;
        got_addr.delete();
        got_data.delete();
        repeat (RESET_CYCLES) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        check_bit("halted", halted, 1'b0);
        cycles = 0;
        while (!halted && cycles < 4 * STEP_LIMIT)
        begin
            @(negedge clock);
            cycles++;
        end
        if (!halted)
        begin
            $display("test %s: halted did not rise within %0d cycles", name, cycles);
            errors++;
        end
        exp_halted = isa_run(image, STEP_LIMIT, exp_addr, exp_data);
        check_bit("halted", halted, exp_halted);
        if (got_addr.size() != exp_addr.size())
        begin
            $display("test %s: expected %0d stores but saw %0d", name, exp_addr.size(),
                     got_addr.size());
            errors++;
        end
        for (int i = 0; i < got_addr.size() && i < exp_addr.size(); i++)
        begin
            check_addr("store_addr", got_addr[i], exp_addr[i]);
            check_word("store_data", got_data[i], exp_data[i]);
        end
        seen = got_addr.size();
        repeat (idle_cycles)
        begin
            @(negedge clock);
            check_bit("halted", halted, 1'b1);
        end
        if (got_addr.size() != seen)
        begin
            $display("test %s: %0d stores appeared after halt", name, got_addr.size() - seen);
            errors++;
        end
        tests_run++;
        if (errors != errors_before)
            tests_failed++;
        $display("test %s: %s", name, (errors == errors_before) ? "pass" : "fail");
    endtask

    initial
    begin
        opcode_t     ops [8];
        int          p;
        logic [31:0] r1;
        logic [31:0] r2;
        clock        = 1'b0;
        rst_n        = 1'b0;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        lcg_state    = 32'h2de6_c065;
        ops = '{`OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_XOR, `OP_ADDI, `OP_SETLO, `OP_SETHI};

        // operands 0x80001234 and 0x9abcff00, results stored from 0x100 upwards
        clear_image();
        emit(`OP_SETLO, 1, 0, 0, 16'h1234);
        emit(`OP_SETHI, 1, 0, 0, 16'h8000);
        emit(`OP_SETLO, 2, 0, 0, 16'hff00);
        emit(`OP_SETHI, 2, 0, 0, 16'h9abc);
        emit(`OP_SETLO, 7, 0, 0, 16'h0100);
        for (int i = 0; i < 5; i++)
        begin
            emit(ops[i], 3, 1, 2, 16'h0);
            emit(`OP_STORE, 0, 3, 7, 16'h0);
            emit(`OP_ADDI, 7, 7, 0, 16'h0001);
        end
        emit(`OP_HALT, 0, 0, 0, 16'h0);
        run_image("alu", 0);

        // carry, borrow, nonzero xor and zero xor each steer a branch
        clear_image();
        emit(`OP_SETLO, 1, 0, 0, 16'hffff);
        emit(`OP_SETHI, 1, 0, 0, 16'hffff);
        emit(`OP_SETLO, 2, 0, 0, 16'h0001);
        emit(`OP_SETLO, 5, 0, 0, 16'haaaa);
        emit(`OP_SETLO, 6, 0, 0, 16'h5555);
        emit(`OP_SETLO, 7, 0, 0, 16'h0200);
        emit(`OP_ADD, 3, 1, 2, 16'h0);
        emit_branch(3);
        emit(`OP_SUB, 3, 2, 1, 16'h0);
        emit_branch(3);
        emit(`OP_XOR, 3, 1, 2, 16'h0);
        emit_branch(3);
        emit(`OP_XOR, 3, 1, 1, 16'h0);
        emit_branch(3);
        p = plen;
        emit(`OP_JMP, 0, 0, 0, imm_t'(p + 2));
        emit(`OP_STORE, 0, 1, 7, 16'h0);
        emit(`OP_HALT, 0, 0, 0, 16'h0);
        run_image("flags", 0);

        clear_image();
        emit(`OP_SETHI, 1, 0, 0, 16'hdead);
        emit(`OP_SETLO, 1, 0, 0, 16'hbeef);
        emit(`OP_ADDI, 2, 0, 0, 16'hffff);
        emit(`OP_SETLO, 2, 0, 0, 16'h0042);
        emit(`OP_ADDI, 3, 0, 0, 16'h7abc);
        emit(`OP_SETHI, 3, 0, 0, 16'h0000);
        emit(`OP_SETLO, 7, 0, 0, 16'h0180);
        for (int i = 1; i <= 3; i++)
        begin
            emit(`OP_STORE, 0, reg_idx_t'(i), 7, 16'h0);
            emit(`OP_ADDI, 7, 7, 0, 16'h0001);
        end
        emit(`OP_HALT, 0, 0, 0, 16'h0);
        run_image("half words", 0);

        clear_image();
        emit(`OP_SETLO, 1, 0, 0, 16'h1111);
        emit(`OP_SETHI, 1, 0, 0, 16'h2222);
        emit(`OP_SETLO, 7, 0, 0, 16'h0280);
        emit(`OP_ADDI, 6, 7, 0, 16'h0001);
        emit(`OP_STORE, 0, 1, 7, 16'h0);
        emit(`OP_STORE, 0, 7, 6, 16'h0);
        emit(`OP_LOAD, 2, 0, 7, 16'h0);
        emit(`OP_LOAD, 3, 0, 6, 16'h0);
        emit(`OP_ADDI, 2, 2, 0, 16'h0005);
        emit(`OP_ADDI, 3, 3, 0, 16'hfffd);
        emit(`OP_SETLO, 5, 0, 0, 16'h0300);
        emit(`OP_LOAD, 4, 0, 5, 16'h0);
        emit(`OP_STORE, 0, 2, 7, 16'h0);
        emit(`OP_STORE, 0, 3, 6, 16'h0);
        emit(`OP_STORE, 0, 4, 6, 16'h0);
        emit(`OP_HALT, 0, 0, 0, 16'h0);
        image['h300] = 32'hc0ff_ee11;
        run_image("load store", 0);

        for (int t = 0; t < 3; t++)
        begin
            clear_image();
            for (int i = 0; i < 40; i++)
            begin
                r1 = lcg_next();
                r2 = lcg_next();
                emit(ops[r1[31:29]], r1[28:26], r1[25:23], r1[22:20], r2[31:16]);
            end
            // each register goes to the address that it holds
            for (int i = 0; i < 8; i++)
            begin
                emit(`OP_STORE, 0, reg_idx_t'(i), reg_idx_t'(i), 16'h0);
            end
            emit(`OP_HALT, 0, 0, 0, 16'h0);
            run_image($sformatf("random %0d", t), 0);
        end

        clear_image();
        emit(`OP_SETLO, 5, 0, 0, 16'h0077);
        emit(`OP_STORE, 0, 5, 5, 16'h0);
        emit(`OP_HALT, 0, 0, 0, 16'h0);
        run_image("halt hold", IDLE_CYCLES);

        // r5 was written before the reset and must read back as zero
        clear_image();
        emit(`OP_SETLO, 1, 0, 0, 16'h03a0);
        emit(`OP_STORE, 0, 5, 1, 16'h0);
        emit(`OP_HALT, 0, 0, 0, 16'h0);
        run_image("restart", 0);

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: octo_system.f
+incdir+common
+incdir+test
common/octo_pkg.sv
cpu/octo_alu.sv
cpu/octo_regfile.sv
cpu/octo_cpu.sv
logic/octo_memory.sv
logic/octo_system.sv
test/octo_tb.sv
